//--- flist.f
src/vote_pkg.sv
src/vote_sender.sv
src/vote_fifo.sv
src/tally_counter.sv
src/vote_tally_top.sv
test/tb_vote_tally.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the vote tally testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_vote_tally

rm -rf "${BUILD_DIR}" "${LOG_FILE}"

verilator --binary --timing -Wno-fatal \
    --top-module "${TOP}" \
    --Mdir "${BUILD_DIR}" \
    -o "V${TOP}" \
    -f flist.f

"./${BUILD_DIR}/V${TOP}" 2>&1 | tee "${LOG_FILE}"

if grep -q "^Test OK$" "${LOG_FILE}"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see ${LOG_FILE}"
    exit 1
fi

//--- src/tally_counter.sv
`timescale 1ns/1ps
`default_nettype none

module tally_counter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 empty,
    input  vote_pkg::vote_word_t head_word,
    output logic                 pop,
    output logic                 credit_return,
    input  logic                 hold,
    input  logic                 flush,
    output vote_pkg::tally_t     tally,
    output logic                 sign_bit
);

    import vote_pkg::*;

    group_sum_t grp_next [GROUP_NUM];
    group_sum_t grp_sum  [GROUP_NUM];
    logic       sum_valid;
    tally_t     grp_total;

    // take a word whenever one is there and not paused
    assign pop = !empty && !hold;

    // group sums of the head word
    // each vote sign-extended to the group width
    always_comb begin
        vote_t v;
        for (int g = 0; g < GROUP_NUM; g++) begin
            grp_next[g] = '0;
            for (int i = 0; i < GROUP_SIZE; i++) begin
                v = head_word[VOTE_W*(g*GROUP_SIZE + i) +: VOTE_W];
                grp_next[g] = grp_next[g] + group_sum_t'(v);
            end
        end
    end

    // stage one, sums registered on the pop edge
    always_ff @(posedge clk) begin
        if (pop) begin
            for (int g = 0; g < GROUP_NUM; g++) begin
                grp_sum[g] <= grp_next[g];
            end
        end
    end

    // stage one valid flag
    always_ff @(posedge clk) begin
        if (rst) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= pop;
        end
    end

    // all four groups widened to tally width
    always_comb begin
        grp_total = '0;
        for (int g = 0; g < GROUP_NUM; g++) begin
            grp_total = grp_total + tally_t'(grp_sum[g]);
        end
    end

    // stage two, accumulate
    // flush wins over an add in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            tally <= '0;
        end else if (flush) begin
            tally <= '0;
        end else if (sum_valid) begin
            tally <= tally + grp_total;
        end
    end

    // one credit back per popped word, a cycle late
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;
        end
    end

    // msb of the signed tally
    assign sign_bit = tally[TALLY_W-1];

endmodule

`default_nettype wire

//--- src/vote_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module vote_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  vote_pkg::vote_word_t push_word,
    input  logic                 pop,
    output logic                 empty,
    output vote_pkg::vote_word_t head_word
);

    import vote_pkg::*;

    // storage
    vote_word_t mem [FIFO_DEPTH];

    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;
    logic        do_pop;

    // no full flag, credits keep the sender from overrunning
    assign empty = (count == '0);

    // pop on an empty buffer is dropped
    assign do_pop = pop && !empty;

    // head is valid whenever not empty
    assign head_word = mem[rd_ptr];

    // write side
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    // pointers wrap at FIFO_DEPTH
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    // occupancy
    // push and pop together leave it unchanged
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/vote_pkg.sv
`default_nettype none

package vote_pkg;

    // core and group layout, fixed 4x4 tree
    localparam int CORE_NUM   = 16;
    localparam int GROUP_SIZE = 4;
    localparam int GROUP_NUM  = 4;

    // accumulator width, 30 bits covers a 1 GB address range count
    localparam int TALLY_W = 30;

    // buffer entries, also the credit count after reset
    localparam int FIFO_DEPTH = 4;

    // derived widths
    localparam int VOTE_W      = 2;
    localparam int VOTE_WORD_W = CORE_NUM * VOTE_W;
    localparam int GROUP_SUM_W = 4;
    localparam int CREDIT_W    = 3;
    localparam int PTR_W       = 2;

    // one bit per core
    typedef logic [CORE_NUM-1:0] core_mask_t;

    // signed vote, holds -1, 0 or +1
    typedef logic signed [VOTE_W-1:0] vote_t;

    // core k sits in bits 2k+1..2k
    typedef logic [VOTE_WORD_W-1:0] vote_word_t;

    // sum of one group, -4..+4
    typedef logic signed [GROUP_SUM_W-1:0] group_sum_t;

    typedef logic signed [TALLY_W-1:0] tally_t;

    // credits run 0..FIFO_DEPTH
    typedef logic [CREDIT_W-1:0] credit_t;

    // buffer read/write pointers and occupancy
    typedef logic [PTR_W-1:0]    fifo_ptr_t;
    typedef logic [CREDIT_W-1:0] fifo_count_t;

    // vote encodings
    localparam vote_t VOTE_POS  = 2'sb01;
    localparam vote_t VOTE_NEG  = 2'sb11;
    localparam vote_t VOTE_ZERO = 2'sb00;

    typedef enum logic {
        send_empty,
        send_full
    } sender_state_t;

endpackage

`default_nettype wire

//--- src/vote_sender.sv
`timescale 1ns/1ps
`default_nettype none

module vote_sender (
    input  logic                 clk,
    input  logic                 rst,
    input  vote_pkg::core_mask_t store,
    input  vote_pkg::core_mask_t core_result,
    output logic                 store_ready,
    output logic                 push,
    output vote_pkg::vote_word_t push_word,
    input  logic                 credit_return
);

    import vote_pkg::*;

    sender_state_t state;
    vote_word_t    new_word;
    vote_word_t    hold_word;
    credit_t       credits;
    logic          store_event;

    // per-core selector, one vote per core
    // store low gives 0, otherwise result picks +1 or -1
    always_comb begin
        for (int k = 0; k < CORE_NUM; k++) begin
            if (!store[k]) begin
                new_word[VOTE_W*k +: VOTE_W] = VOTE_ZERO;
            end else if (core_result[k]) begin
                new_word[VOTE_W*k +: VOTE_W] = VOTE_POS;
            end else begin
                new_word[VOTE_W*k +: VOTE_W] = VOTE_NEG;
            end
        end
    end

    // ready only while the hold register is free
    assign store_ready = (state == send_empty);

    // any store bit in a ready cycle
    assign store_event = (|store) && store_ready;

    // held word goes out once a credit is there
    assign push      = (state == send_full) && (credits != '0);
    assign push_word = hold_word;

    // single-entry holding FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= send_empty;
        end else begin
            case (state)
                send_empty: begin
                    if (store_event) begin
                        state <= send_full;
                    end
                end
                send_full: begin
                    // leaves when the push is taken
                    if (push) begin
                        state <= send_empty;
                    end
                end
                default: begin
                    state <= send_empty;
                end
            endcase
        end
    end

    // payload, loaded on the store event edge
    always_ff @(posedge clk) begin
        if (store_event) begin
            hold_word <= new_word;
        end
    end

    // credit counter
    // push spends one, credit_return gives one back, both at once cancel
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= credit_t'(FIFO_DEPTH);
        end else begin
            case ({push, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/vote_tally_top.sv
`timescale 1ns/1ps
`default_nettype none

module vote_tally_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 hold,
    input  logic                 flush,
    input  vote_pkg::core_mask_t store,
    input  vote_pkg::core_mask_t core_result,
    output logic                 store_ready,
    output logic                 sign_bit,
    output vote_pkg::tally_t     tally
);

    import vote_pkg::*;

    // sender to buffer
    logic       push;
    vote_word_t push_word;

    // buffer to counter
    logic       empty;
    logic       pop;
    vote_word_t head_word;

    // counter back to sender
    logic       credit_return;

    // producer, maps strobes to votes and spends credits
    vote_sender sender_i (
        .clk           (clk),
        .rst           (rst),
        .store         (store),
        .core_result   (core_result),
        .store_ready   (store_ready),
        .push          (push),
        .push_word     (push_word),
        .credit_return (credit_return)
    );

    // vote word buffer
    vote_fifo fifo_i (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_word (push_word),
        .pop       (pop),
        .empty     (empty),
        .head_word (head_word)
    );

    // consumer, two-stage adder tree and accumulator
    tally_counter counter_i (
        .clk           (clk),
        .rst           (rst),
        .empty         (empty),
        .head_word     (head_word),
        .pop           (pop),
        .credit_return (credit_return),
        .hold          (hold),
        .flush         (flush),
        .tally         (tally),
        .sign_bit      (sign_bit)
    );

endmodule

`default_nettype wire

//--- test/tb_vote_tally.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vote_tally;

    import vote_pkg::*;

    // test lengths
    localparam int BURST_N      = 200;
    localparam int FLUSH_N      = 100;
    localparam int SPECIAL_N    = 4;
    localparam int MAX_GAP      = 3;
    localparam int HOLD_CYCLES  = 16;
    localparam int MIX_ROUNDS   = 12;
    localparam int MIX_SEGS     = 3;
    localparam int SEG_MAX      = 8;
    localparam int DRAIN_CYCLES = 20;

    // worst case per event is gap plus ready wait plus drive cycle
    localparam int EVENT_CYCLES   = MAX_GAP + 8;
    localparam int STIM_CYCLES    = (BURST_N + FLUSH_N + SPECIAL_N) * EVENT_CYCLES
                                    + HOLD_CYCLES + MIX_ROUNDS * MIX_SEGS * SEG_MAX;
    localparam int DRAIN_COUNT    = 4 + SPECIAL_N + MIX_ROUNDS;
    localparam int TIMEOUT_CYCLES = 2 * (STIM_CYCLES + DRAIN_COUNT * DRAIN_CYCLES) + 200;

    logic       clk;
    logic       rst;
    logic       hold;
    logic       flush;
    core_mask_t store;
    core_mask_t core_result;
    logic       store_ready;
    logic       sign_bit;
    tally_t     tally;

    // reference model state
    tally_t      model_tally;
    logic [31:0] lcg_state;
    int          cycle_count = 0;

    vote_tally_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .hold        (hold),
        .flush       (flush),
        .store       (store),
        .core_result (core_result),
        .store_ready (store_ready),
        .sign_bit    (sign_bit),
        .tally       (tally)
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit from the test lengths plus margin
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // 32-bit LCG whose upper bits are the useful ones
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // +1 per set result bit and -1 per clear one where store is set
    function automatic int vote_sum(input core_mask_t s, input core_mask_t r);
        int sum;
        sum = 0;
        for (int k = 0; k < CORE_NUM; k++) begin
            if (s[k]) begin
                sum = r[k] ? sum + 1 : sum - 1;
            end
        end
        return sum;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_tally(input string name, input tally_t got, input tally_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    // tally and sign against the model
    task automatic check_model();
        check_tally("tally", tally, model_tally);
        check_bit("sign_bit", sign_bit, model_tally[TALLY_W-1]);
    endtask

    // one store event after waiting for a free hold register
    task automatic accept_store(input core_mask_t s, input core_mask_t r);
        while (!store_ready) begin
            @(negedge clk);
        end
        store       = s;
        core_result = r;
        if (|s) begin
            model_tally = model_tally + tally_t'(vote_sum(s, r));
        end
        @(negedge clk);
        store = '0;
    endtask

    // random nonzero store mask followed by a short idle gap
    task automatic random_store();
        logic [31:0] r1;
        logic [31:0] r2;
        core_mask_t  s;
        r1 = lcg_next();
        r2 = lcg_next();
        s  = r1[31:16];
        if (s == '0) begin
            s = core_mask_t'(1);
        end
        accept_store(s, r2[31:16]);
        repeat (int'(r1[15:14])) @(negedge clk);
    endtask

    // idle inputs long enough to empty the pipeline
    task automatic drain();
        hold  = 1'b0;
        flush = 1'b0;
        store = '0;
        repeat (DRAIN_CYCLES) @(negedge clk);
    endtask

    // single flush cycle so tally reads 0 right after
    task automatic flush_tally();
        flush = 1'b1;
        @(negedge clk);
        flush       = 1'b0;
        model_tally = '0;
        check_tally("tally", tally, '0);
        check_bit("sign_bit", sign_bit, 1'b0);
    endtask

    // fixed hold level with stores offered at random when ready
    task automatic run_segment(input logic hold_val, input int len);
        logic [31:0] r1;
        logic [31:0] r2;
        for (int c = 0; c < len; c++) begin
            r1   = lcg_next();
            r2   = lcg_next();
            hold = hold_val;
            if (store_ready && r1[31]) begin
                store       = r1[30:15];
                core_result = r2[31:16];
                if (|store) begin
                    model_tally = model_tally + tally_t'(vote_sum(store, core_result));
                end
            end else begin
                store = '0;
            end
            @(negedge clk);
        end
        store = '0;
    endtask

    // stores every cycle under hold until back-pressure closes the input
    task automatic hold_test();
        tally_t      frozen;
        logic [31:0] r1;
        logic [31:0] r2;
        core_mask_t  s;
        int          accepted;
        frozen   = model_tally;
        accepted = 0;
        hold     = 1'b1;
        for (int c = 0; c < HOLD_CYCLES; c++) begin
            r1 = lcg_next();
            r2 = lcg_next();
            check_tally("tally", tally, frozen);
            if (store_ready) begin
                s = r1[31:16];
                if (s == '0) begin
                    s = core_mask_t'(1);
                end
                store       = s;
                core_result = r2[31:16];
                model_tally = model_tally + tally_t'(vote_sum(s, r2[31:16]));
                accepted++;
            end else begin
                store = '0;
            end
            @(negedge clk);
        end
        store = '0;
        check_bit("store_ready", store_ready, 1'b0);
        check_tally("tally", tally, frozen);
        if (accepted > FIFO_DEPTH + 1) begin
            fail_now($sformatf("%0d stores were accepted under hold, more than the buffer holds",
                               accepted));
        end
        // after release every held word must land exactly once
        drain();
        check_model();
    endtask

    initial begin
        lcg_state   = 32'd18172;
        rst         = 1'b1;
        hold        = 1'b0;
        flush       = 1'b0;
        store       = '0;
        core_result = '0;
        model_tally = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // state right after reset
        check_tally("tally", tally, '0);
        check_bit("sign_bit", sign_bit, 1'b0);
        check_bit("store_ready", store_ready, 1'b1);

        // random burst without hold
        repeat (BURST_N) random_store();
        drain();
        check_model();

        // fixed words on a cleared tally with sums +16 -16 -16 and 0
        flush_tally();
        accept_store(16'hFFFF, 16'hFFFF);
        drain();
        check_tally("tally", tally, tally_t'(16));
        accept_store(16'hFFFF, 16'h0000);
        drain();
        check_model();
        accept_store(16'hFFFF, 16'h0000);
        drain();
        check_tally("tally", tally, tally_t'(-16));
        check_bit("sign_bit", sign_bit, 1'b1);
        // alternating results cancel out
        accept_store(16'hFFFF, 16'h5555);
        drain();
        check_model();

        // back-pressure
        hold_test();

        // flush followed by traffic on the cleared tally
        flush_tally();
        repeat (FLUSH_N) random_store();
        drain();
        check_model();

        // hold toggling mixed with stores
        for (int rnd = 0; rnd < MIX_ROUNDS; rnd++) begin
            for (int seg = 0; seg < MIX_SEGS; seg++) begin
                logic [31:0] r;
                r = lcg_next();
                run_segment(r[31], 1 + int'(r[30:28]));
            end
            drain();
            check_model();
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
